/* hw/lcdPkg.sv */
`default_nettype none

package lcdPkg;

   // ------------------------------
   // LCD bus widths
   // ------------------------------
   localparam int NibbleWidth = 4;   // display runs in 4-bit mode
   localparam int WaitWidth   = 20;  // enough for 750k cycles

   typedef logic [7:0] lcdByteT;     // one command or data byte

   // ------------------------------
   // nibble writer opcodes
   // ------------------------------
   typedef enum logic
   {
      opNibble = 1'b0,               // low nibble only, init phase
      opByte   = 1'b1                // high nibble then low nibble
   } writeOpT;

   // ------------------------------
   // sequencer states
   // ------------------------------
   typedef enum logic [4:0]
   {
      stPowerWait = 5'd0,            // long wait after power-on
      stInitSend  = 5'd1,            // init nibble 3,3,3,2
      stInitWait  = 5'd2,
      stCfgSend   = 5'd3,            // 0x28 0x06 0x0C 0x01
      stCfgWait   = 5'd4,
      stIdle      = 5'd5,            // ready for host bytes
      stHostSend  = 5'd6,
      stHostWait  = 5'd7
   } seqStateT;

   // function set 0x28 is two lines, 5x8 font
   // entry mode 0x06 increments the cursor, no shift

endpackage

`default_nettype wire

/* hw/lcdDelayTimer.sv */
`timescale 1ns/1ps
`default_nettype none

module lcdDelayTimer import lcdPkg::*; (
   input  logic                 Clock,
   input  logic                 rstN,
   input  logic                 tmLoad,      // restart with a new wait
   input  logic [WaitWidth-1:0] tmCount,     // wait length in cycles
   output logic                 tmExpired    // level, held until next load
);

   logic [WaitWidth-1:0] count;              // cycles still to go
   logic                 armed;              // some wait loaded since reset

   // ------------------------------
   // down-counter
   // ------------------------------
   always_ff @(posedge Clock)
   begin
      if (!rstN)
      begin
         count <= '0;
         armed <= 1'b0;                      // no expiry before first load
      end
      else if (tmLoad)
      begin
         count <= tmCount;
         armed <= 1'b1;
      end
      else if (count != '0)
      begin
         count <= count - 1'b1;              // parks at zero
      end
   end

   assign tmExpired = armed && (count == '0);

   // once at zero and not reloaded, the counter must not wrap to all ones
   assert property (@(posedge Clock) disable iff (!rstN)
      (!tmLoad && count == '0) |=> (count == '0))
      else $error("wait counter wrapped below zero");

endmodule

`default_nettype wire

/* hw/lcdNibbleWriter.sv */
`timescale 1ns/1ps
`default_nettype none

module lcdNibbleWriter import lcdPkg::*; #(
   parameter int unsigned EnableWidth = 12,   // enable high time in cycles
   parameter int unsigned NibbleGap   = 1     // extra low time between nibbles
) (
   input  logic                   Clock,
   input  logic                   rstN,
   input  logic                   wrStart,    // ignored while busy
   input  writeOpT                wrOp,
   input  lcdByteT                wrByte,
   input  logic                   wrRs,
   output logic                   wrDone,     // one-cycle pulse
   output logic                   wrBusy,
   output logic [NibbleWidth-1:0] lcdData,
   output logic                   lcdEnable,
   output logic                   lcdRs
);

   localparam int unsigned CntWidth = $clog2(NibbleGap + EnableWidth + 1);

   typedef enum logic [2:0]
   {
      phIdle,
      phHigh,                                 // high nibble pulse
      phGap,                                  // enable low between nibbles
      phLow,                                  // low nibble pulse
      phDone                                  // one cycle before wrDone
   } phaseT;

   phaseT               phase;
   logic [CntWidth-1:0] cnt;                  // pulse and gap width
   lcdByteT             byteReg;              // byte being sent
   logic                accept;

   assign accept = wrStart && (phase == phIdle);
   assign wrBusy = (phase != phIdle);

   // byte kept for the second nibble
   always_ff @(posedge Clock)
   begin
      if (accept)
      begin
         byteReg <= wrByte;
      end
   end

   // ------------------------------
   // phase sequencing
   // ------------------------------
   always_ff @(posedge Clock)
   begin
      if (!rstN)
      begin
         phase     <= phIdle;
         cnt       <= '0;
         lcdEnable <= 1'b0;
         lcdData   <= '0;
         lcdRs     <= 1'b0;
         wrDone    <= 1'b0;
      end
      else
      begin
         wrDone <= 1'b0;                      // default, pulse only
         unique case (phase)
            phIdle:
            begin
               if (accept)
               begin
                  lcdEnable <= 1'b1;          // rises 1 cycle after start
                  lcdRs     <= wrRs;
                  cnt       <= CntWidth'(EnableWidth - 1);
                  if (wrOp == opByte)
                  begin
                     lcdData <= wrByte[2*NibbleWidth-1:NibbleWidth];
                     phase   <= phHigh;
                  end
                  else
                  begin
                     lcdData <= wrByte[NibbleWidth-1:0];
                     phase   <= phLow;        // single nibble, init only
                  end
               end
            end
            phHigh:
            begin
               if (cnt == '0)
               begin
                  lcdEnable <= 1'b0;
                  cnt       <= CntWidth'(NibbleGap + EnableWidth - 1);
                  phase     <= phGap;
               end
               else
               begin
                  cnt <= cnt - 1'b1;
               end
            end
            phGap:
            begin
               lcdData <= byteReg[NibbleWidth-1:0];   // one cycle after fall
               if (cnt == '0)
               begin
                  lcdEnable <= 1'b1;
                  cnt       <= CntWidth'(EnableWidth - 1);
                  phase     <= phLow;
               end
               else
               begin
                  cnt <= cnt - 1'b1;
               end
            end
            phLow:
            begin
               if (cnt == '0)
               begin
                  lcdEnable <= 1'b0;          // last fall
                  phase     <= phDone;
               end
               else
               begin
                  cnt <= cnt - 1'b1;
               end
            end
            phDone:
            begin
               wrDone <= 1'b1;
               phase  <= phIdle;
            end
            default: phase <= phIdle;
         endcase
      end
   end

   // pins must hold still for the whole pulse
   assert property (@(posedge Clock) disable iff (!rstN)
      (lcdEnable && $past(lcdEnable)) |-> ($stable(lcdData) && $stable(lcdRs)))
      else $error("lcdData moved while enable high");

   assert property (@(posedge Clock) disable iff (!rstN) !(wrDone && lcdEnable))
      else $error("wrDone during an enable pulse");

endmodule

`default_nettype wire

/* hw/lcdSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module lcdSequencer import lcdPkg::*; #(
   parameter int unsigned PowerOnWait = 750000,
   parameter int unsigned InitWait    = 205000,
   parameter int unsigned ShortWait   = 5000,
   parameter int unsigned CmdWait     = 2000,
   parameter int unsigned ClearWait   = 85000
) (
   input  logic                 Clock,
   input  logic                 rstN,
   input  logic                 wrDone,
   input  logic                 wrBusy,
   input  logic                 tmExpired,
   input  logic                 bufValid,
   input  lcdByteT              bufByte,
   input  logic                 bufIsData,
   output logic                 wrStart,     // pulse
   output writeOpT              wrOp,
   output lcdByteT              wrByte,
   output logic                 wrRs,
   output logic                 tmLoad,      // pulse
   output logic [WaitWidth-1:0] tmCount,
   output logic                 bufTake,     // pulse, host byte consumed
   output logic                 initDone
);

   seqStateT             state;
   logic [1:0]           step;               // init or config step index
   logic                 issued;             // start or load already sent
   lcdByteT              stepByte;
   logic [WaitWidth-1:0] stepWait;

   // ------------------------------
   // per-step byte and wait
   // ------------------------------
   always_comb
   begin
      stepByte = 8'h00;
      stepWait = WaitWidth'(CmdWait);        // host bytes and most commands
      unique case (state)
         stPowerWait: stepWait = WaitWidth'(PowerOnWait);
         stInitSend, stInitWait:
         begin
            stepByte = (step == 2'd3) ? 8'h02 : 8'h03;   // 3,3,3 then 2
            if (step == 2'd0)
            begin
               stepWait = WaitWidth'(InitWait);
            end
            else if (step == 2'd1)
            begin
               stepWait = WaitWidth'(ShortWait);
            end
         end
         stCfgSend, stCfgWait:
         begin
            unique case (step)
               2'd0: stepByte = 8'h28;       // function set
               2'd1: stepByte = 8'h06;       // entry mode
               2'd2: stepByte = 8'h0C;       // display on, cursor off
               default:
               begin
                  stepByte = 8'h01;          // clear, slow on the display
                  stepWait = WaitWidth'(ClearWait);
               end
            endcase
         end
         default: ;
      endcase
   end

   // ------------------------------
   // main FSM
   // ------------------------------
   always_ff @(posedge Clock)
   begin
      if (!rstN)
      begin
         state    <= stPowerWait;
         step     <= 2'd0;
         issued   <= 1'b0;
         wrStart  <= 1'b0;
         wrOp     <= opNibble;
         wrByte   <= '0;
         wrRs     <= 1'b0;
         tmLoad   <= 1'b0;
         tmCount  <= '0;
         bufTake  <= 1'b0;
         initDone <= 1'b0;
      end
      else
      begin
         wrStart <= 1'b0;
         tmLoad  <= 1'b0;
         bufTake <= 1'b0;
         unique case (state)
            stPowerWait, stInitWait, stCfgWait, stHostWait:
            begin
               if (!issued)
               begin
                  tmLoad  <= 1'b1;           // first cycle in wait
                  tmCount <= stepWait;
                  issued  <= 1'b1;
               end
               else if (tmExpired && !tmLoad)   // old expiry still visible
               begin
                  issued <= 1'b0;
                  if (state == stPowerWait)
                  begin
                     state <= stInitSend;
                  end
                  else if (state == stHostWait)
                  begin
                     state <= stIdle;
                  end
                  else
                  begin
                     step <= step + 2'd1;    // wraps to 0 for config
                     if (step != 2'd3)
                     begin
                        state <= (state == stInitWait) ? stInitSend : stCfgSend;
                     end
                     else if (state == stInitWait)
                     begin
                        state <= stCfgSend;
                     end
                     else
                     begin
                        state    <= stIdle;
                        initDone <= 1'b1;    // host may write now
                     end
                  end
               end
            end
            stInitSend, stCfgSend:
            begin
               if (!issued && !wrBusy)
               begin
                  wrStart <= 1'b1;
                  wrByte  <= stepByte;
                  wrOp    <= (state == stInitSend) ? opNibble : opByte;
                  wrRs    <= 1'b0;           // commands
                  issued  <= 1'b1;
               end
               else if (wrDone)
               begin
                  issued <= 1'b0;
                  state  <= (state == stInitSend) ? stInitWait : stCfgWait;
               end
            end
            stIdle:
            begin
               if (bufValid && !wrBusy)
               begin
                  wrStart <= 1'b1;
                  wrByte  <= bufByte;
                  wrOp    <= opByte;
                  wrRs    <= bufIsData;      // address 1 is data
                  bufTake <= 1'b1;           // frees the slave buffer
                  state   <= stHostSend;
               end
            end
            stHostSend:
            begin
               if (wrDone)
               begin
                  state <= stHostWait;
               end
            end
            default: state <= stPowerWait;
         endcase
      end
   end

   // writer drops starts while busy, so none may be issued then
   assert property (@(posedge Clock) disable iff (!rstN) wrStart |-> !wrBusy)
      else $error("wrStart while writer busy");

endmodule

`default_nettype wire

/* hw/lcdBusSlave.sv */
`timescale 1ns/1ps
`default_nettype none

module lcdBusSlave import lcdPkg::*; (
   input  logic    Clock,
   input  logic    rstN,
   input  logic    wbCyc,
   input  logic    wbStb,
   input  logic    wbWe,
   input  logic    wbAdr,                     // 0 command, 1 data
   input  lcdByteT wbDatIn,
   input  logic    bufTake,
   input  logic    initDone,
   output lcdByteT wbDatOut,                  // status byte
   output logic    wbAck,
   output logic    bufValid,
   output lcdByteT bufByte,
   output logic    bufIsData
);

   logic request;                             // live cycle, not yet acked
   logic accept;

   // no second ack while the master still holds stb after the first
   assign request = wbCyc && wbStb && !wbAck;
   // writes stall until the buffer is free and init finished
   assign accept  = request && (!wbWe || (!bufValid && initDone));

   // ------------------------------
   // ack and buffer state
   // ------------------------------
   always_ff @(posedge Clock)
   begin
      if (!rstN)
      begin
         wbAck    <= 1'b0;
         bufValid <= 1'b0;
      end
      else
      begin
         wbAck <= accept;                     // one cycle after accept
         if (accept && wbWe)
         begin
            bufValid <= 1'b1;
         end
         else if (bufTake)
         begin
            bufValid <= 1'b0;                 // sequencer took it
         end
      end
   end

   // byte payload
   always_ff @(posedge Clock)
   begin
      if (accept && wbWe)
      begin
         bufByte   <= wbDatIn;
         bufIsData <= wbAdr;
      end
   end

   assign wbDatOut = {6'b0, initDone, initDone && !bufValid};

   assert property (@(posedge Clock) disable iff (!rstN)
      (wbAck && wbCyc && wbStb) |=> !wbAck)
      else $error("wbAck held two cycles in one transaction");

endmodule

`default_nettype wire

/* hw/lcdController.sv */
`timescale 1ns/1ps
`default_nettype none

module lcdController import lcdPkg::*; #(
   parameter int unsigned PowerOnWait = 750000,   // 15 ms at 50 MHz
   parameter int unsigned InitWait    = 205000,   // 4.1 ms
   parameter int unsigned ShortWait   = 5000,     // 100 us
   parameter int unsigned CmdWait     = 2000,     // 40 us
   parameter int unsigned ClearWait   = 85000,    // clear needs ~1.64 ms
   parameter int unsigned EnableWidth = 12,
   parameter int unsigned NibbleGap   = 1
) (
   input  logic                   Clock,
   input  logic                   rstN,
   input  logic                   wbCyc,
   input  logic                   wbStb,
   input  logic                   wbWe,
   input  logic                   wbAdr,
   input  lcdByteT                wbDatIn,
   output lcdByteT                wbDatOut,
   output logic                   wbAck,
   output logic [NibbleWidth-1:0] lcdData,
   output logic                   lcdEnable,
   output logic                   lcdRs
);

   // ------------------------------
   // internal links
   // ------------------------------
   logic                 bufValid;
   lcdByteT              bufByte;
   logic                 bufIsData;
   logic                 bufTake;
   logic                 initDone;
   logic                 wrStart;
   writeOpT              wrOp;
   lcdByteT              wrByte;
   logic                 wrRs;
   logic                 wrDone;
   logic                 wrBusy;
   logic                 tmLoad;
   logic [WaitWidth-1:0] tmCount;
   logic                 tmExpired;

   lcdBusSlave lcdBusSlave_inst (
      .Clock, .rstN, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatIn,
      .bufTake, .initDone, .wbDatOut, .wbAck, .bufValid, .bufByte, .bufIsData
   );

   lcdSequencer #(
      .PowerOnWait (PowerOnWait),
      .InitWait    (InitWait),
      .ShortWait   (ShortWait),
      .CmdWait     (CmdWait),
      .ClearWait   (ClearWait)
   ) lcdSequencer_inst (
      .Clock, .rstN, .wrDone, .wrBusy, .tmExpired, .bufValid, .bufByte, .bufIsData,
      .wrStart, .wrOp, .wrByte, .wrRs, .tmLoad, .tmCount, .bufTake, .initDone
   );

   lcdNibbleWriter #(
      .EnableWidth (EnableWidth),
      .NibbleGap   (NibbleGap)
   ) lcdNibbleWriter_inst (
      .Clock, .rstN, .wrStart, .wrOp, .wrByte, .wrRs,
      .wrDone, .wrBusy, .lcdData, .lcdEnable, .lcdRs
   );

   lcdDelayTimer lcdDelayTimer_inst (
      .Clock, .rstN, .tmLoad, .tmCount, .tmExpired
   );

endmodule

`default_nettype wire

/* tb/lcdControllerTb.sv */
`timescale 1ns/1ps
`default_nettype none

module lcdControllerTb import lcdPkg::*; ();

   localparam int PowerOnWait = 200;
   localparam int InitWait    = 80;
   localparam int ShortWait   = 40;
   localparam int CmdWait     = 20;
   localparam int ClearWait   = 60;
   localparam int EnableWidth = 4;
   localparam int NibbleGap   = 1;
   localparam int HostBytes   = 18;                     // 16 random, 2 back-pressure
   localparam int WaitSum     = PowerOnWait + InitWait + ShortWait + 5 * CmdWait + ClearWait;
   localparam int TimeoutCycles = 2 * (WaitSum + 100 * HostBytes);

   logic             Clock;
   logic             rstN;
   logic             wbCyc;
   logic             wbStb;
   logic             wbWe;
   logic             wbAdr;
   lcdByteT          wbDatIn;
   lcdByteT          wbDatOut;
   logic             wbAck;
   logic [NibbleWidth-1:0] lcdData;
   logic             lcdEnable;
   logic             lcdRs;

   // ------------------------------
   // expected pulses, one entry each
   // ------------------------------
   logic [3:0] expNib[$];
   logic       expRs[$];
   int         expGap[$];                               // min low time before rise
   logic       expExact[$];                             // gap must match exactly
   int         riseCycles[$];                           // cycle of every rise

   int         cycles = 0;
   int         errors = 0;
   int         checks = 0;
   int         popCount = 0;
   int         pulseCount = 0;                          // every fall, expected or not
   int         widthFails = 0;
   int         hostCount = 0;
   int         lastAckCycle = 0;
   logic [15:0] lfsr = 16'd51252;

   lcdController #(
      .PowerOnWait (PowerOnWait),
      .InitWait    (InitWait),
      .ShortWait   (ShortWait),
      .CmdWait     (CmdWait),
      .ClearWait   (ClearWait),
      .EnableWidth (EnableWidth),
      .NibbleGap   (NibbleGap)
   ) lcdController_inst (
      .Clock, .rstN, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatIn,
      .wbDatOut, .wbAck, .lcdData, .lcdEnable, .lcdRs
   );

   initial Clock = 1'b0;
   always #50 Clock = ~Clock;                           // 100 ns period

   // cycle count and run limit
   always @(posedge Clock)
   begin
      cycles <= cycles + 1;
      if (cycles >= TimeoutCycles)
      begin
         $display("timeout: no finish within %0d cycles", TimeoutCycles);
         $display("Something failed");
         $finish;
      end
   end

   task automatic checkEqual(input logic [31:0] got, input logic [31:0] expected,
                             input string what);
      checks++;
      if (got !== expected)
      begin
         $display("MISMATCH at %0t: %s, got %0h expected %0h", $time, what, got, expected);
         errors++;
      end
   endtask

   // 16-bit Galois LFSR, taps 16 14 13 11
   function automatic logic [15:0] lfsrNext(input logic [15:0] s);
      logic [15:0] n;
      n = s >> 1;
      if (s[0])
      begin
         n = n ^ 16'hB400;
      end
      return n;
   endfunction

   function automatic logic [7:0] randomBits(input int count);
      logic [7:0] v;
      v = '0;
      for (int i = 0; i < count; i++)
      begin
         lfsr = lfsrNext(lfsr);                         // one step per bit
         v    = {v[6:0], lfsr[0]};
      end
      return v;
   endfunction

   task automatic pushNibble(input logic [3:0] nib, input logic rs, input int gap,
                             input logic exact);
      expNib.push_back(nib);
      expRs.push_back(rs);
      expGap.push_back(gap);
      expExact.push_back(exact);
   endtask

   // high nibble after the previous wait, low nibble after the fixed gap
   task automatic pushByte(input logic [7:0] b, input logic rs, input int gap);
      pushNibble(b[7:4], rs, gap, 1'b0);
      pushNibble(b[3:0], rs, NibbleGap + EnableWidth, 1'b1);
   endtask

   // ------------------------------
   // Wishbone master
   // ------------------------------
   task automatic writeByte(input logic adr, input logic [7:0] dat);
      @(posedge Clock);
      #1;
      wbCyc   = 1'b1;
      wbStb   = 1'b1;
      wbWe    = 1'b1;
      wbAdr   = adr;
      wbDatIn = dat;
      @(negedge Clock);
      while (!wbAck)
         @(negedge Clock);                              // held off while buffer full
      lastAckCycle = cycles;
      pushByte(dat, adr, (hostCount == 0) ? ClearWait : CmdWait);
      hostCount++;
      @(posedge Clock);
      #1;
      wbCyc = 1'b0;
      wbStb = 1'b0;
      wbWe  = 1'b0;
   endtask

   task automatic readStatus(output logic [7:0] status);
      @(posedge Clock);
      #1;
      wbCyc = 1'b1;
      wbStb = 1'b1;
      wbWe  = 1'b0;
      @(negedge Clock);
      while (!wbAck)
         @(negedge Clock);
      status = wbDatOut;
      @(posedge Clock);
      #1;
      wbCyc = 1'b0;
      wbStb = 1'b0;
   endtask

   task automatic comparePulse(input int width, input int gap, input logic [3:0] nib,
                               input logic rs);
      int   minGap;
      logic exact;
      pulseCount++;
      if (expNib.size() == 0)
      begin
         $display("unexpected enable pulse at %0t, nibble %0h", $time, nib);
         errors++;
      end
      else
      begin
         minGap = expGap.pop_front();
         exact  = expExact.pop_front();
         checkEqual(nib, expNib.pop_front(), $sformatf("nibble of pulse %0d", popCount));
         checkEqual(rs, expRs.pop_front(), $sformatf("rs of pulse %0d", popCount));
         if (exact)
            checkEqual(gap, minGap, $sformatf("gap inside byte, pulse %0d", popCount));
         else
            checkEqual(gap >= minGap, 1, $sformatf("wait before pulse %0d", popCount));
         popCount++;
      end
      if (width != EnableWidth)
      begin
         widthFails++;
      end
      checkEqual(width, EnableWidth, "enable pulse width");
   endtask

   // ------------------------------
   // LCD pin monitor
   // ------------------------------
   logic       prevEn;
   int         lowCount;
   int         highCount;
   int         gapSeen;
   logic [3:0] heldData;
   logic       heldRs;

   always @(negedge Clock)                              // pins settled mid-cycle
   begin
      if (!rstN)
      begin
         prevEn   = 1'b0;
         lowCount = 0;
      end
      else if (lcdEnable && !prevEn)
      begin
         riseCycles.push_back(cycles);
         highCount = 1;
         gapSeen   = lowCount;
         heldData  = lcdData;
         heldRs    = lcdRs;
      end
      else if (lcdEnable)
      begin
         highCount++;
         if (lcdData != heldData || lcdRs != heldRs)
         begin
            widthFails++;
         end
         checkEqual({lcdRs, lcdData}, {heldRs, heldData}, "pins moved during enable");
      end
      else if (prevEn)
      begin
         comparePulse(highCount, gapSeen, heldData, heldRs);   // fall
         lowCount = 1;
      end
      else
      begin
         lowCount++;
      end
      prevEn = (rstN) ? lcdEnable : 1'b0;
   end

   // ------------------------------
   // test sequence
   // ------------------------------
   initial
   begin
      int         mark;
      int         riseMark;
      logic [7:0] status;
      logic       adrBit;
      logic [7:0] datByte;
      rstN    = 1'b0;
      wbCyc   = 1'b0;
      wbStb   = 1'b0;
      wbWe    = 1'b0;
      wbAdr   = 1'b0;
      wbDatIn = '0;
      pushNibble(4'h3, 1'b0, PowerOnWait, 1'b0);        // power-on init nibbles
      pushNibble(4'h3, 1'b0, InitWait, 1'b0);
      pushNibble(4'h3, 1'b0, ShortWait, 1'b0);
      pushNibble(4'h2, 1'b0, CmdWait, 1'b0);
      pushByte(8'h28, 1'b0, CmdWait);                   // configuration bytes
      pushByte(8'h06, 1'b0, CmdWait);
      pushByte(8'h0C, 1'b0, CmdWait);
      pushByte(8'h01, 1'b0, CmdWait);
      repeat (3) @(posedge Clock);
      #1;
      rstN = 1'b1;

      mark = errors;
      @(negedge Clock);
      checkEqual(lcdEnable, 1'b0, "enable after reset");
      checkEqual(wbAck, 1'b0, "ack after reset");
      readStatus(status);
      checkEqual(status, 8'h00, "status during power wait");
      while (popCount < 4)
         @(negedge Clock);
      $display("test 1 init nibbles: %s", (errors == mark) ? "ok" : "failed");

      mark = errors;
      status = '0;
      while (!status[0])
         readStatus(status);                            // poll until ready
      checkEqual(status, 8'h03, "status after init");
      checkEqual(popCount, 12, "pulses during init");
      $display("test 2 configuration: %s", (errors == mark) ? "ok" : "failed");

      mark = errors;
      for (int i = 0; i < 16; i++)
      begin
         adrBit  = 1'(randomBits(1));
         datByte = randomBits(8);
         writeByte(adrBit, datByte);
      end
      while (expNib.size() != 0)
         @(negedge Clock);
      $display("test 4 random host bytes: %s", (errors == mark) ? "ok" : "failed");

      mark     = errors;
      riseMark = riseCycles.size();
      writeByte(1'b1, randomBits(8));
      writeByte(1'b0, randomBits(8));                   // stalls on the full buffer
      while (expNib.size() != 0)
         @(negedge Clock);
      // a repeated byte would start within one host wait after the last fall
      repeat (2 * (CmdWait + NibbleGap + 2 * EnableWidth)) @(negedge Clock);
      checkEqual(riseCycles[riseMark] < lastAckCycle, 1, "second ack before first pulse");
      checkEqual(pulseCount, 12 + 2 * HostBytes, "pulses after back-pressure");
      $display("test 5 back-pressure: %s", (errors == mark) ? "ok" : "failed");

      $display("test 3 pulse width and hold: %s (%0d pulses)",
               (widthFails == 0) ? "ok" : "failed", popCount);
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

`default_nettype wire

/* build.f */
hw/lcdPkg.sv
hw/lcdDelayTimer.sv
hw/lcdNibbleWriter.sv
hw/lcdSequencer.sv
hw/lcdBusSlave.sv
hw/lcdController.sv
tb/lcdControllerTb.sv

/* Makefile */
# Verilator build and run of the LCD controller testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module lcdControllerTb -Mdir obj_dir
	./obj_dir/VlcdControllerTb > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^Everything OK$$" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
